// ==== mem_bus_pkg.sv ====
package mem_bus_pkg;

	// width of fetch addresses and of the memory-side line address.
	localparam int ADDR_W = 32;

	localparam int WORD_W = 32;

	// one instruction word as seen by the fetch side.
	typedef logic [WORD_W-1:0] word_t;

	localparam int LINE_WORDS = 4;

	// byte offset within a line, and the part of it that picks a word.
	localparam int OFFSET_BITS = 4;
	localparam int WORD_LSB = 2;
	localparam int WORD_SEL_BITS = OFFSET_BITS - WORD_LSB;

	// word 0 of the line occupies the low bits.
	typedef logic [LINE_WORDS*WORD_W-1:0] line_t;

endpackage

// ==== cache_cfg_pkg.sv ====
package cache_cfg_pkg;

	// associativity of the instruction cache.
	localparam int NUM_WAYS = 4;

	// one bit per way, used both one-hot and as a hit vector.
	typedef logic [NUM_WAYS-1:0] way_t;

	// the replacement pointer starts on way 0.
	localparam way_t RR_FIRST = way_t'(1);

endpackage

// ==== sram_1p.sv ====
`timescale 1ns/100ps

module sram_1p #(
	parameter int DEPTH = 64,
	parameter type T = logic [31:0]
) (
	input logic clk,
	input logic en,
	input logic we,
	input logic [$clog2(DEPTH)-1:0] a,
	input T wdata,
	output T rdata
);

	T mem [DEPTH];

	// rdata only changes on an enabled read, so it holds across stalls.
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[a] <= wdata;
			end else begin
				rdata <= mem[a];
			end
		end
	end

endmodule

// ==== refill_ctrl.sv ====
`timescale 1ns/100ps

module refill_ctrl import mem_bus_pkg::*; (
	input logic clk,
	input logic rst,
	input logic refill_start,
	input logic [ADDR_W-1:0] refill_addr,
	output line_t refill_line,
	output logic refill_done,
	output logic mem_req,
	output logic [ADDR_W-1:0] mem_addr,
	input logic mem_ack,
	input line_t mem_line
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_REQ,
		S_REL,
		S_DONE
	} state_t;

	state_t state;
	state_t state_nxt;
	logic [ADDR_W-1:0] addr_q;
	line_t line_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			S_IDLE: begin
				if (refill_start) begin
					state_nxt = S_REQ;
				end
			end
			S_REQ: begin
				if (mem_ack) begin
					state_nxt = S_REL;
				end
			end
			// the memory has to release ack before the next request may start.
			S_REL: begin
				if (!mem_ack) begin
					state_nxt = S_DONE;
				end
			end
			default: begin
				state_nxt = S_IDLE;
			end
		endcase
	end

	// the address is taken at start and stays put for the whole handshake.
	always_ff @(posedge clk) begin
		if (state == S_IDLE && refill_start) begin
			addr_q <= refill_addr;
		end
		if (state == S_REQ && mem_ack) begin
			line_q <= mem_line;
		end
	end

	assign mem_req = (state == S_REQ);
	assign mem_addr = addr_q;

	// the captured line is held until the next refill, the cache reads it late
	// when its output stage is stalled.
	assign refill_done = (state == S_DONE);
	assign refill_line = line_q;

endmodule

// ==== icache.sv ====
`timescale 1ns/100ps

module icache import mem_bus_pkg::*, cache_cfg_pkg::*; #(
	parameter int SET_BITS = 6
) (
	input logic clk,
	input logic rst,
	input logic [ADDR_W-1:0] addr,
	input logic valid,
	output logic accept,
	input logic flush,
	output word_t inst,
	output logic inst_valid,
	input logic out_ready,
	output logic refill_start,
	output logic [ADDR_W-1:0] refill_addr,
	input line_t refill_line,
	input logic refill_done
);

	localparam int DEPTH = 2 ** SET_BITS;
	localparam int TAG_W = ADDR_W - SET_BITS - OFFSET_BITS;

	typedef logic [TAG_W-1:0] tag_t;

	logic [ADDR_W-1:0] lk_addr;
	logic lk_valid;
	logic refilling;
	logic fill_pend;
	logic fill_kill;
	logic install;
	logic [DEPTH-1:0] vld [NUM_WAYS];
	way_t victim;
	tag_t lk_tag;
	logic [SET_BITS-1:0] lk_idx;
	logic [SET_BITS-1:0] arr_idx;
	logic [WORD_SEL_BITS-1:0] lk_word;
	tag_t tag_rd [NUM_WAYS];
	line_t data_rd [NUM_WAYS];
	way_t hit_vec;
	line_t hit_line;
	logic lookup_live;
	logic lookup_hit;
	logic lookup_miss;
	logic out_free;
	logic kill_now;
	logic fill_fire;
	logic req_take;

	function automatic word_t word_of(input line_t line, input logic [WORD_SEL_BITS-1:0] sel);
		return line[sel*WORD_W +: WORD_W];
	endfunction

	assign lk_tag = lk_addr[ADDR_W-1 -: TAG_W];
	assign lk_idx = lk_addr[OFFSET_BITS +: SET_BITS];
	assign lk_word = lk_addr[WORD_LSB +: WORD_SEL_BITS];

	// the install cycle owns the single-ported arrays while accept is low.
	assign arr_idx = install ? lk_idx : addr[OFFSET_BITS +: SET_BITS];

	genvar w;
	generate
		for (w = 0; w < NUM_WAYS; w++) begin : g_way
			sram_1p #(
				.DEPTH(DEPTH),
				.T(tag_t)
			) tag_ram (
				.clk(clk),
				.en(req_take || (install && victim[w])),
				.we(install && victim[w]),
				.a(arr_idx),
				.wdata(lk_tag),
				.rdata(tag_rd[w])
			);

			sram_1p #(
				.DEPTH(DEPTH),
				.T(line_t)
			) data_ram (
				.clk(clk),
				.en(req_take || (install && victim[w])),
				.we(install && victim[w]),
				.a(arr_idx),
				.wdata(refill_line),
				.rdata(data_rd[w])
			);

			assign hit_vec[w] = vld[w][lk_idx] && (tag_rd[w] == lk_tag);
		end
	endgenerate

	always_comb begin
		hit_line = '0;
		for (int i = 0; i < NUM_WAYS; i++) begin
			if (hit_vec[i]) begin
				hit_line = hit_line | data_rd[i];
			end
		end
	end

	// the hit check is only meaningful until a refill has been started.
	assign lookup_live = lk_valid && !refilling;
	assign lookup_hit = lookup_live && (|hit_vec);
	assign lookup_miss = lookup_live && !(|hit_vec);

	assign out_free = !inst_valid || out_ready;
	assign kill_now = fill_kill || flush;

	// a returned line is consumed once the output stage can take its word,
	// or at once when nobody wants the word any more.
	assign fill_fire = refilling && (refill_done || fill_pend) && (kill_now || out_free);

	assign accept = !rst && out_free && !install && !refilling && (!lk_valid || lookup_hit);
	assign req_take = valid && accept;

	assign refill_start = lookup_miss;
	assign refill_addr = {lk_addr[ADDR_W-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

	always_ff @(posedge clk) begin
		if (rst) begin
			lk_valid <= 1'b0;
			refilling <= 1'b0;
			fill_pend <= 1'b0;
			fill_kill <= 1'b0;
			install <= 1'b0;
		end else begin
			install <= fill_fire;
			if (req_take) begin
				lk_valid <= 1'b1;
			end else if (lookup_hit && (out_free || flush)) begin
				lk_valid <= 1'b0;
			end else if (fill_fire) begin
				lk_valid <= 1'b0;
			end
			if (lookup_miss) begin
				refilling <= 1'b1;
			end else if (fill_fire) begin
				refilling <= 1'b0;
			end
			if (fill_fire) begin
				fill_pend <= 1'b0;
			end else if (refilling && refill_done) begin
				fill_pend <= 1'b1;
			end
			// a flushed miss still completes and installs its line.
			if (fill_fire) begin
				fill_kill <= 1'b0;
			end else if (flush && (lookup_miss || refilling)) begin
				fill_kill <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req_take) begin
			lk_addr <= addr;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			inst_valid <= 1'b0;
		end else if (flush) begin
			inst_valid <= 1'b0;
		end else if (lookup_hit && out_free) begin
			inst_valid <= 1'b1;
		end else if (fill_fire && !fill_kill) begin
			inst_valid <= 1'b1;
		end else if (out_ready) begin
			inst_valid <= 1'b0;
		end
	end

	// on a miss the word comes straight from the returned line.
	always_ff @(posedge clk) begin
		if (lookup_hit && out_free) begin
			inst <= word_of(hit_line, lk_word);
		end else if (fill_fire && !kill_now) begin
			inst <= word_of(refill_line, lk_word);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			victim <= RR_FIRST;
			for (int i = 0; i < NUM_WAYS; i++) begin
				vld[i] <= '0;
			end
		end else if (install) begin
			victim <= {victim[NUM_WAYS-2:0], victim[NUM_WAYS-1]};
			for (int i = 0; i < NUM_WAYS; i++) begin
				if (victim[i]) begin
					vld[i][lk_idx] <= 1'b1;
				end
			end
		end
	end

endmodule

// ==== fetch_top.sv ====
`timescale 1ns/100ps

module fetch_top import mem_bus_pkg::*; #(
	parameter int SET_BITS = 6
) (
	input logic clk,
	input logic rst,
	input logic [ADDR_W-1:0] addr,
	input logic valid,
	output logic accept,
	input logic flush,
	output word_t inst,
	output logic inst_valid,
	input logic out_ready,
	output logic mem_req,
	output logic [ADDR_W-1:0] mem_addr,
	input logic mem_ack,
	input line_t mem_line
);

	logic refill_start;
	logic [ADDR_W-1:0] refill_addr;
	line_t refill_line;
	logic refill_done;

	icache #(
		.SET_BITS(SET_BITS)
	) icache_i (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.valid(valid),
		.accept(accept),
		.flush(flush),
		.inst(inst),
		.inst_valid(inst_valid),
		.out_ready(out_ready),
		.refill_start(refill_start),
		.refill_addr(refill_addr),
		.refill_line(refill_line),
		.refill_done(refill_done)
	);

	// one miss at a time goes out over the four-phase memory port.
	refill_ctrl refill_ctrl_i (
		.clk(clk),
		.rst(rst),
		.refill_start(refill_start),
		.refill_addr(refill_addr),
		.refill_line(refill_line),
		.refill_done(refill_done),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_ack(mem_ack),
		.mem_line(mem_line)
	);

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// reset covers the first two rising edges and drops on a falling edge.
	initial begin
		rst = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

// ==== mem_model.sv ====
`timescale 1ns/100ps

module mem_model import mem_bus_pkg::*; (
	input logic clk,
	input logic rst,
	input logic mem_req,
	input logic [ADDR_W-1:0] mem_addr,
	input logic [2:0] ack_delay,
	output logic mem_ack,
	output line_t mem_line
);

	logic [2:0] wait_cnt;

	// every word holds its own byte address with a fixed pattern mixed in.
	function automatic line_t line_at(input logic [ADDR_W-1:0] a);
		line_t l;
		logic [ADDR_W-1:0] wa;
		int w;
		for (w = 0; w < LINE_WORDS; w++) begin
			wa = {a[ADDR_W-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}} + ADDR_W'(w * 4);
			l[w*WORD_W +: WORD_W] = wa ^ 32'hc0de0000;
		end
		return l;
	endfunction

	always @(posedge clk) begin
		if (rst) begin
			mem_ack <= 1'b0;
			mem_line <= '0;
			wait_cnt <= '0;
		end else if (mem_ack) begin
			// release only after the master has dropped its request.
			if (!mem_req) begin
				mem_ack <= 1'b0;
			end
		end else if (mem_req) begin
			mem_line <= line_at(mem_addr);
			if (wait_cnt == ack_delay) begin
				mem_ack <= 1'b1;
				wait_cnt <= '0;
			end else begin
				wait_cnt <= wait_cnt + 3'd1;
			end
		end
	end

endmodule

// ==== icache_checker.sv ====
`timescale 1ns/100ps

module icache_checker import mem_bus_pkg::*; (
	input logic clk,
	input logic rst,
	input logic flush,
	input logic out_ready,
	input word_t inst,
	input logic inst_valid,
	input logic mem_req,
	input logic mem_ack,
	input logic [ADDR_W-1:0] mem_addr
);

	// the request and its address stay up until the memory answers.
	req_held: assert property (@(posedge clk) disable iff (rst)
		mem_req && !mem_ack |=> mem_req && $stable(mem_addr))
		else $error("mem_req dropped or mem_addr moved before mem_ack");

	output_held: assert property (@(posedge clk) disable iff (rst)
		inst_valid && !out_ready && !flush |=> inst_valid && $stable(inst))
		else $error("inst or inst_valid changed while out_ready was low");

	// no instruction may appear right after reset or a flush.
	quiet_after: assert property (@(posedge clk)
		rst || flush |=> !inst_valid)
		else $error("inst_valid high in the cycle after reset or flush");

endmodule

bind fetch_top icache_checker icache_checker_i (
	.clk(clk),
	.rst(rst),
	.flush(flush),
	.out_ready(out_ready),
	.inst(inst),
	.inst_valid(inst_valid),
	.mem_req(mem_req),
	.mem_ack(mem_ack),
	.mem_addr(mem_addr)
);

// ==== icache_tb.sv ====
`timescale 1ns/100ps

module icache_tb import mem_bus_pkg::*, cache_cfg_pkg::*; ();

	localparam int SET_BITS = 6;
	localparam int TAG_W = ADDR_W - SET_BITS - OFFSET_BITS;
	localparam int DIRECTED_ROWS = 20;
	localparam int RANDOM_ROWS = 24;
	localparam int TIMEOUT = (DIRECTED_ROWS + RANDOM_ROWS) * 20 + 50;

	typedef struct {
		logic [ADDR_W-1:0] addr;
		bit flush;
		int stall;
		bit hit;
		logic [2:0] delay;
	} row_t;

	logic clk;
	logic rst;
	logic [ADDR_W-1:0] addr;
	logic valid;
	logic accept;
	logic flush;
	word_t inst;
	logic inst_valid;
	logic out_ready;
	logic mem_req;
	logic [ADDR_W-1:0] mem_addr;
	logic mem_ack;
	line_t mem_line;
	logic [2:0] ack_delay;

	row_t rows[$];
	int errors = 0;
	int checks = 0;
	int req_rises = 0;
	int deliveries = 0;
	int cycles = 0;
	logic req_last = 1'b0;
	logic [ADDR_W-1:0] req_addr = '0;

	tb_clock_gen clock_gen_i (.clk(clk), .rst(rst));

	fetch_top #(.SET_BITS(SET_BITS)) fetch_top_i (
		.clk(clk), .rst(rst), .addr(addr), .valid(valid), .accept(accept),
		.flush(flush), .inst(inst), .inst_valid(inst_valid), .out_ready(out_ready),
		.mem_req(mem_req), .mem_addr(mem_addr), .mem_ack(mem_ack), .mem_line(mem_line)
	);

	mem_model mem_model_i (
		.clk(clk), .rst(rst), .mem_req(mem_req), .mem_addr(mem_addr),
		.ack_delay(ack_delay), .mem_ack(mem_ack), .mem_line(mem_line)
	);

	always @(posedge clk) begin
		if (!rst) begin
			if (mem_req && !req_last) begin
				req_rises++;
				req_addr = mem_addr;
			end
			if (inst_valid && out_ready) begin
				deliveries++;
			end
		end
		req_last <= mem_req;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic add_row(input logic [ADDR_W-1:0] a, input bit fl, input int st);
		row_t r;
		r.addr = a;
		r.flush = fl;
		r.stall = st;
		r.hit = 1'b0;
		r.delay = 3'(1 + $urandom % 4);
		rows.push_back(r);
	endtask

	task automatic build_table();
		logic [ADDR_W-1:0] a;
		bit fl;
		int k;
		add_row(32'h0000_1000, 0, 0);
		for (k = 0; k < LINE_WORDS; k++) begin
			add_row(32'h0000_1000 + 4 * k, 0, 0);
		end
		// five lines in set 4, the four survivors, then the evicted line.
		for (k = 0; k < 5; k++) begin
			add_row(32'h0000_2040 + k * 32'h400, 0, 0);
		end
		add_row(32'h0000_2448, 0, 0);
		add_row(32'h0000_2844, 0, 0);
		add_row(32'h0000_2c48, 0, 0);
		add_row(32'h0000_304c, 0, 0);
		add_row(32'h0000_2040, 0, 0);
		add_row(32'h0000_1004, 0, 4);
		add_row(32'h0000_5000, 0, 3);
		add_row(32'h0000_1008, 1, 0);
		add_row(32'h0000_6000, 1, 0);
		add_row(32'h0000_6008, 0, 0);
		// a small address window so that random rows both hit and miss.
		for (k = 0; k < RANDOM_ROWS; k++) begin
			a = $urandom & 32'h0000_1c3c;
			fl = ($urandom % 6) == 0;
			add_row(a, fl, fl ? 0 : $urandom % 3);
		end
	endtask

	// replays the table through a model of the tags, valid bits and the shared pointer.
	function automatic void predict_hits();
		bit valid_bits [2**SET_BITS][NUM_WAYS];
		logic [TAG_W-1:0] tags [2**SET_BITS][NUM_WAYS];
		int ptr;
		int set;
		int w;
		logic [TAG_W-1:0] tag;
		ptr = 0;
		foreach (rows[n]) begin
			set = rows[n].addr[OFFSET_BITS +: SET_BITS];
			tag = rows[n].addr[ADDR_W-1 -: TAG_W];
			rows[n].hit = 1'b0;
			for (w = 0; w < NUM_WAYS; w++) begin
				if (valid_bits[set][w] && tags[set][w] == tag) begin
					rows[n].hit = 1'b1;
				end
			end
			if (!rows[n].hit) begin
				valid_bits[set][ptr] = 1'b1;
				tags[set][ptr] = tag;
				ptr = (ptr + 1) % NUM_WAYS;
			end
		end
	endfunction

	task automatic run_row(input int n);
		logic [ADDR_W-1:0] a;
		word_t expected;
		word_t held;
		int rises0;
		int delivered0;
		int errors0;
		int lat;
		int k;
		a = rows[n].addr;
		expected = {a[ADDR_W-1:2], 2'b00} ^ 32'hc0de0000;
		rises0 = req_rises;
		delivered0 = deliveries;
		errors0 = errors;
		@(negedge clk);
		addr = a;
		valid = 1'b1;
		out_ready = (rows[n].stall == 0);
		ack_delay = rows[n].delay;
		@(posedge clk);
		while (!accept) begin
			@(posedge clk);
		end
		@(negedge clk);
		valid = 1'b0;
		flush = rows[n].flush;
		if (rows[n].flush) begin
			@(negedge clk);
			flush = 1'b0;
			// a flushed miss keeps accept low until its line is installed.
			@(posedge clk);
			while (!accept) begin
				@(posedge clk);
			end
			@(negedge clk);
		end else begin
			lat = 0;
			while (!inst_valid) begin
				@(posedge clk);
				lat++;
				@(negedge clk);
			end
			if (rows[n].hit) begin
				check_value("hit latency", lat, 1);
			end
			check_value("inst", inst, expected);
			held = inst;
			for (k = 0; k < rows[n].stall; k++) begin
				check_value("accept", accept, 0);
				@(negedge clk);
				check_value("inst_valid", inst_valid, 1);
				check_value("inst", inst, held);
			end
			out_ready = 1'b1;
			@(negedge clk);
			check_value("inst_valid", inst_valid, 0);
		end
		check_value("mem_req rises", req_rises - rises0, rows[n].hit ? 0 : 1);
		if (!rows[n].hit) begin
			check_value("mem_addr", req_addr, {a[ADDR_W-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}});
		end
		check_value("deliveries", deliveries - delivered0, rows[n].flush ? 0 : 1);
		$display("row %0d: addr %h flush %0d stall %0d %s, %s", n, a, rows[n].flush,
			rows[n].stall, rows[n].hit ? "hit" : "miss",
			(errors == errors0) ? "ok" : "mismatch");
	endtask

	initial begin
		addr = '0;
		valid = 1'b0;
		flush = 1'b0;
		out_ready = 1'b1;
		ack_delay = 3'd1;
		void'($urandom(32'h25cb));
		build_table();
		predict_hits();
		// the handshake and output signals stay quiet while reset is held.
		@(posedge clk);
		@(negedge clk);
		check_value("accept", accept, 0);
		check_value("inst_valid", inst_valid, 0);
		check_value("mem_req", mem_req, 0);
		wait (rst == 1'b0);
		for (int n = 0; n < rows.size(); n++) begin
			run_row(n);
		end
		$display("%0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// ==== build.f ====
mem_bus_pkg.sv
cache_cfg_pkg.sv
sram_1p.sv
refill_ctrl.sv
icache.sv
fetch_top.sv
tb_clock_gen.sv
mem_model.sv
icache_checker.sv
icache_tb.sv
